/* hdl/cpu_pkg.sv */
/*
 * shared definitions for the 16-bit pipelined load/store cpu
 *   opcode enum, datapath and field widths
 *   memory address widths, nop encoding
 *   program image file name
 */

package cpu_pkg;

   ////////////////////
   // widths
   ////////////////////

   localparam int word_width      = 16;
   localparam int reg_addr_width  = 3;
   localparam int num_regs        = 8;
   localparam int op_width        = 4;
   localparam int imm_width       = 6;

   // byte addressed, bit 0 ignored
   localparam int imem_addr_width = 10;
   localparam int dmem_addr_width = 10;

   ////////////////////
   // opcodes
   ////////////////////

   // held in instr[15:12]
   typedef enum logic [op_width-1:0] {
      op_nop  = 4'h0,
      op_add  = 4'h1,
      op_sub  = 4'h2,
      op_and  = 4'h3,
      op_or   = 4'h4,
      op_addi = 4'h5,
      op_ld   = 4'h6,
      op_st   = 4'h7,
      op_beqz = 4'h8,
      op_halt = 4'h9
   } opcode_e;

   // all-zero word decodes as nop
   localparam logic [word_width-1:0] nop_instr = 16'h0000;

   // hex image for the instruction memory
   localparam string imem_image = "prog.hex";

endpackage

/* hdl/instr_mem.sv */
/*
 * instruction memory
 *   byte addressed, 16-bit words, addr bit 0 ignored
 *   combinational read, image loaded on first reset cycle
 */

module instr_mem (
   input  logic                                clk,
   input  logic                                rst,
   input  logic [cpu_pkg::imem_addr_width-1:0] addr,
   output logic [cpu_pkg::word_width-1:0]      data_out
);

   import cpu_pkg::*;

   // one entry per 16-bit word
   logic [word_width-1:0] mem [2**(imem_addr_width-1)];

   // set once the image is in, survives later resets
   logic loaded = 1'b0;

   // word select, low bit dropped
   assign data_out = mem[addr[imem_addr_width-1:1]];

   // image load on the first reset only
   always_ff @(posedge clk) begin
      if (rst && !loaded) begin
         $readmemh(imem_image, mem);
         loaded <= 1'b1;
      end
   end

endmodule

/* hdl/data_mem.sv */
/*
 * data memory
 *   byte addressed, 16-bit words, addr bit 0 ignored
 *   enable with wr low reads combinationally
 *   enable with wr high writes on the rising edge
 */

module data_mem (
   input  logic                                clk,
   input  logic                                rst,
   input  logic [cpu_pkg::dmem_addr_width-1:0] addr,
   input  logic [cpu_pkg::word_width-1:0]      data_in,
   input  logic                                enable,
   input  logic                                wr,
   output logic [cpu_pkg::word_width-1:0]      data_out
);

   import cpu_pkg::*;

   logic [word_width-1:0] mem [2**(dmem_addr_width-1)];

   // read, zero when idle or writing
   assign data_out = (enable && !wr) ? mem[addr[dmem_addr_width-1:1]] : '0;

   // write port
   // nothing lands while the core sits in reset
   always_ff @(posedge clk) begin
      if (!rst && enable && wr) begin
         mem[addr[dmem_addr_width-1:1]] <= data_in;
      end
   end

endmodule

/* hdl/reg_file.sv */
/*
 * register file
 *   eight 16-bit registers, r0 hardwired to zero
 *   two combinational read ports, one write port
 *   write-through bypass on same-cycle read
 */

module reg_file (
   input  logic                               clk,
   input  logic                               rst,
   input  logic [cpu_pkg::reg_addr_width-1:0] rs,
   input  logic [cpu_pkg::reg_addr_width-1:0] rt,
   input  logic                               wr_en,
   input  logic [cpu_pkg::reg_addr_width-1:0] wr_reg,
   input  logic [cpu_pkg::word_width-1:0]     wr_data,
   output logic [cpu_pkg::word_width-1:0]     rs_data,
   output logic [cpu_pkg::word_width-1:0]     rt_data
);

   import cpu_pkg::*;

   logic [word_width-1:0] regs [num_regs];

   // r0 first, then bypass, then array
   always_comb begin
      if (rs == '0) rs_data = '0;
      else if (wr_en && (wr_reg == rs)) rs_data = wr_data;
      else rs_data = regs[rs];
      if (rt == '0) rt_data = '0;
      else if (wr_en && (wr_reg == rt)) rt_data = wr_data;
      else rt_data = regs[rt];
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         regs <= '{default: '0};
      end else if (wr_en && (wr_reg != '0)) begin
         regs[wr_reg] <= wr_data;
      end
   end

endmodule

/* hdl/fetch_stage.sv */
/*
 * fetch stage
 *   program counter with stall, halt freeze and branch load
 *   instruction memory access
 *   fetch/decode register, nop on flush or halt
 */

module fetch_stage (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           stall,
   input  logic                           halt_seen,
   input  logic                           br_taken,
   input  logic [cpu_pkg::word_width-1:0] br_target,
   output logic [cpu_pkg::word_width-1:0] if_instr,
   output logic [cpu_pkg::word_width-1:0] if_pc_next
);

   import cpu_pkg::*;

   logic [word_width-1:0] pc;
   logic [word_width-1:0] pc_plus2;
   logic [word_width-1:0] fetch_data;

   assign pc_plus2 = pc + 16'd2;

   instr_mem imem_i (
      .clk      (clk),
      .rst      (rst),
      .addr     (pc[imem_addr_width-1:0]),
      .data_out (fetch_data)
   );

   // branch wins over stall and halt
   always_ff @(posedge clk) begin
      if (rst) pc <= '0;
      else if (br_taken) pc <= br_target;
      else if (!stall && !halt_seen) pc <= pc_plus2;
   end

   // fetch/decode register
   always_ff @(posedge clk) begin
      if (rst || br_taken || halt_seen) if_instr <= nop_instr;
      else if (!stall) if_instr <= fetch_data;
   end

   // return pc travels with the instruction
   always_ff @(posedge clk) begin
      if (!stall) if_pc_next <= pc_plus2;
   end

endmodule

/* hdl/decode_stage.sv */
/*
 * decode stage
 *   field split, operand read, immediate sign extension
 *   load-use style hazard stall against execute and mem_wb
 *   halt detection and decode/execute register
 */

module decode_stage (
   input  logic                               clk,
   input  logic                               rst,
   input  logic [cpu_pkg::word_width-1:0]     if_instr,
   input  logic [cpu_pkg::word_width-1:0]     if_pc_next,
   input  logic                               br_taken,
   input  logic [cpu_pkg::reg_addr_width-1:0] ex_rd,
   input  logic                               ex_wr_en,
   input  logic                               wb_valid,
   input  logic [cpu_pkg::reg_addr_width-1:0] wb_reg,
   input  logic [cpu_pkg::word_width-1:0]     wb_data,
   output logic                               stall,
   output logic                               halt_seen,
   output cpu_pkg::opcode_e                   id_op,
   output logic [cpu_pkg::reg_addr_width-1:0] id_rd,
   output logic                               id_wr_en,
   output logic [cpu_pkg::word_width-1:0]     id_a,
   output logic [cpu_pkg::word_width-1:0]     id_b,
   output logic [cpu_pkg::word_width-1:0]     id_imm,
   output logic [cpu_pkg::word_width-1:0]     id_pc_next
);

   import cpu_pkg::*;

   opcode_e                   op;
   logic [reg_addr_width-1:0] rd, rs, rt, rb;
   logic [word_width-1:0]     rs_data, rb_data, imm;
   logic                      use_rs, use_rb, wr_en;
   logic                      rs_hit, rb_hit, halt_hold;

   ////////////////////
   // field split
   ////////////////////
   assign op  = opcode_e'(if_instr[15:12]);
   assign rd  = if_instr[11:9];
   assign rs  = if_instr[8:6];
   assign rt  = if_instr[5:3];
   assign imm = {{(word_width-imm_width){if_instr[imm_width-1]}}, if_instr[imm_width-1:0]};
   // store data comes from rd through the second port
   assign rb  = (op == op_st) ? rd : rt;

   // which sources are live, who writes
   always_comb begin
      use_rs = 1'b0;
      use_rb = 1'b0;
      wr_en  = 1'b0;
      case (op)
         op_add, op_sub, op_and, op_or: begin
            use_rs = 1'b1;
            use_rb = 1'b1;
            wr_en  = 1'b1;
         end
         op_addi, op_ld: begin
            use_rs = 1'b1;
            wr_en  = 1'b1;
         end
         op_st: begin
            use_rs = 1'b1;
            use_rb = 1'b1;
         end
         op_beqz: use_rs = 1'b1;
         default: ;
      endcase
   end

   reg_file rf_i (
      .clk     (clk),
      .rst     (rst),
      .rs      (rs),
      .rt      (rb),
      .wr_en   (wb_valid),
      .wr_reg  (wb_reg),
      .wr_data (wb_data),
      .rs_data (rs_data),
      .rt_data (rb_data)
   );

   ////////////////////
   // hazards and halt
   ////////////////////
   // in flight in execute (id_*) or mem_wb (ex_*)
   assign rs_hit = use_rs && (rs != '0) &&
                   ((id_wr_en && (id_rd == rs)) || (ex_wr_en && (ex_rd == rs)));
   assign rb_hit = use_rb && (rb != '0) &&
                   ((id_wr_en && (id_rd == rb)) || (ex_wr_en && (ex_rd == rb)));
   assign stall  = rs_hit || rb_hit;

   // halt in decode, or one already passed through
   assign halt_seen = halt_hold || (op == op_halt);

   always_ff @(posedge clk) begin
      if (rst) halt_hold <= 1'b0;
      else if ((op == op_halt) && !br_taken) halt_hold <= 1'b1;
   end

   // decode/execute control, bubble on stall or flush
   always_ff @(posedge clk) begin
      if (rst || br_taken || stall) begin
         id_op    <= op_nop;
         id_rd    <= '0;
         id_wr_en <= 1'b0;
      end else begin
         id_op    <= op;
         id_rd    <= rd;
         id_wr_en <= wr_en;
      end
   end

   // operand payload
   always_ff @(posedge clk) begin
      id_a       <= rs_data;
      id_b       <= rb_data;
      id_imm     <= imm;
      id_pc_next <= if_pc_next;
   end

endmodule

/* hdl/execute_stage.sv */
/*
 * execute stage
 *   alu for register ops and address generation
 *   beqz zero test and branch target
 *   execute/memory register
 */

module execute_stage (
   input  logic                               clk,
   input  logic                               rst,
   input  cpu_pkg::opcode_e                   id_op,
   input  logic [cpu_pkg::reg_addr_width-1:0] id_rd,
   input  logic                               id_wr_en,
   input  logic [cpu_pkg::word_width-1:0]     id_a,
   input  logic [cpu_pkg::word_width-1:0]     id_b,
   input  logic [cpu_pkg::word_width-1:0]     id_imm,
   input  logic [cpu_pkg::word_width-1:0]     id_pc_next,
   output logic                               br_taken,
   output logic [cpu_pkg::word_width-1:0]     br_target,
   output cpu_pkg::opcode_e                   ex_op,
   output logic [cpu_pkg::reg_addr_width-1:0] ex_rd,
   output logic                               ex_wr_en,
   output logic [cpu_pkg::word_width-1:0]     ex_result,
   output logic [cpu_pkg::word_width-1:0]     ex_store_data
);

   import cpu_pkg::*;

   logic [word_width-1:0] alu_out;

   ////////////////////
   // alu
   ////////////////////
   always_comb begin
      case (id_op)
         op_add:                alu_out = id_a + id_b;
         op_sub:                alu_out = id_a - id_b;
         op_and:                alu_out = id_a & id_b;
         op_or:                 alu_out = id_a | id_b;
         // immediate add, also ld/st address
         op_addi, op_ld, op_st: alu_out = id_a + id_imm;
         default:               alu_out = '0;
      endcase
   end

   // branch resolves here, pc+2 plus word offset
   assign br_taken  = (id_op == op_beqz) && (id_a == '0);
   assign br_target = id_pc_next + {id_imm[word_width-2:0], 1'b0};

   // execute/memory control
   always_ff @(posedge clk) begin
      if (rst) begin
         ex_op    <= op_nop;
         ex_rd    <= '0;
         ex_wr_en <= 1'b0;
      end else begin
         ex_op    <= id_op;
         ex_rd    <= id_rd;
         ex_wr_en <= id_wr_en;
      end
   end

   // result and store data
   always_ff @(posedge clk) begin
      ex_result     <= alu_out;
      ex_store_data <= id_b;
   end

endmodule

/* hdl/mem_wb_stage.sv */
/*
 * memory and writeback stage
 *   data memory access for ld/st
 *   load or alu result select, writeback port
 *   sticky halted flag
 */

module mem_wb_stage (
   input  logic                               clk,
   input  logic                               rst,
   input  cpu_pkg::opcode_e                   ex_op,
   input  logic [cpu_pkg::reg_addr_width-1:0] ex_rd,
   input  logic                               ex_wr_en,
   input  logic [cpu_pkg::word_width-1:0]     ex_result,
   input  logic [cpu_pkg::word_width-1:0]     ex_store_data,
   output logic                               wb_valid,
   output logic [cpu_pkg::reg_addr_width-1:0] wb_reg,
   output logic [cpu_pkg::word_width-1:0]     wb_data,
   output logic                               halted
);

   import cpu_pkg::*;

   logic                  is_ld, is_st;
   logic [word_width-1:0] ld_data;

   assign is_ld = (ex_op == op_ld);
   assign is_st = (ex_op == op_st);

   // enable for either access, wr only on store
   data_mem dmem_i (
      .clk      (clk),
      .rst      (rst),
      .addr     (ex_result[dmem_addr_width-1:0]),
      .data_in  (ex_store_data),
      .enable   (is_ld || is_st),
      .wr       (is_st),
      .data_out (ld_data)
   );

   // register write lands at the end of this cycle
   assign wb_valid = ex_wr_en;
   assign wb_reg   = ex_rd;
   assign wb_data  = is_ld ? ld_data : ex_result;

   // held until the next reset
   always_ff @(posedge clk) begin
      if (rst) halted <= 1'b0;
      else if (ex_op == op_halt) halted <= 1'b1;
   end

endmodule

/* hdl/cpu_top.sv */
/*
 * cpu top level
 *   fetch, decode, execute and mem_wb stages
 *   writeback port and halted flag brought out
 */

module cpu_top (
   input  logic                               clk,
   input  logic                               rst,
   output logic                               wb_valid,
   output logic [cpu_pkg::reg_addr_width-1:0] wb_reg,
   output logic [cpu_pkg::word_width-1:0]     wb_data,
   output logic                               halted
);

   import cpu_pkg::*;

   // fetch to decode
   logic [word_width-1:0]     if_instr, if_pc_next;
   // decode to fetch
   logic                      stall, halt_seen;
   // decode to execute
   opcode_e                   id_op;
   logic [reg_addr_width-1:0] id_rd;
   logic                      id_wr_en;
   logic [word_width-1:0]     id_a, id_b, id_imm, id_pc_next;
   // execute back to fetch and decode
   logic                      br_taken;
   logic [word_width-1:0]     br_target;
   // execute to mem_wb
   opcode_e                   ex_op;
   logic [reg_addr_width-1:0] ex_rd;
   logic                      ex_wr_en;
   logic [word_width-1:0]     ex_result, ex_store_data;

   ////////////////////
   // stages
   ////////////////////
   fetch_stage fetch_i (
      .clk(clk), .rst(rst), .stall(stall), .halt_seen(halt_seen),
      .br_taken(br_taken), .br_target(br_target),
      .if_instr(if_instr), .if_pc_next(if_pc_next)
   );

   decode_stage decode_i (
      .clk(clk), .rst(rst), .if_instr(if_instr), .if_pc_next(if_pc_next),
      .br_taken(br_taken), .ex_rd(ex_rd), .ex_wr_en(ex_wr_en),
      .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
      .stall(stall), .halt_seen(halt_seen), .id_op(id_op), .id_rd(id_rd),
      .id_wr_en(id_wr_en), .id_a(id_a), .id_b(id_b), .id_imm(id_imm),
      .id_pc_next(id_pc_next)
   );

   execute_stage execute_i (
      .clk(clk), .rst(rst), .id_op(id_op), .id_rd(id_rd), .id_wr_en(id_wr_en),
      .id_a(id_a), .id_b(id_b), .id_imm(id_imm), .id_pc_next(id_pc_next),
      .br_taken(br_taken), .br_target(br_target), .ex_op(ex_op), .ex_rd(ex_rd),
      .ex_wr_en(ex_wr_en), .ex_result(ex_result), .ex_store_data(ex_store_data)
   );

   mem_wb_stage mem_wb_i (
      .clk(clk), .rst(rst), .ex_op(ex_op), .ex_rd(ex_rd), .ex_wr_en(ex_wr_en),
      .ex_result(ex_result), .ex_store_data(ex_store_data),
      .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data), .halted(halted)
   );

endmodule

/* testbench/tb_cpu_top.sv */
/*
 * testbench for cpu_top
 *   clock, reset and cycle timeout
 *   writeback monitor feeding an ordered queue
 *   isa-level register and memory model
 *   value check task and directed test tasks
 */

module tb_cpu_top;

   import cpu_pkg::*;

   // 38 instructions at up to three cycles each with stalls,
   // plus reset, branch bubbles and the halt watch, with wide margin
   localparam int max_cycles = 400;
   // cycles to watch for stray retirements once halted
   localparam int halt_watch = 16;

   logic                      clk;
   logic                      rst;
   logic                      wb_valid;
   logic [reg_addr_width-1:0] wb_reg;
   logic [word_width-1:0]     wb_data;
   logic                      halted;

   // {reg, data} per retirement, in program order
   logic [reg_addr_width+word_width-1:0] wb_queue [$];
   int                                   cycle_count = 0;

   // architectural state as the isa rules give it
   logic [word_width-1:0] model_regs [num_regs];
   logic [word_width-1:0] model_mem [int];

   cpu_top dut_i (
      .clk      (clk),
      .rst      (rst),
      .wb_valid (wb_valid),
      .wb_reg   (wb_reg),
      .wb_data  (wb_data),
      .halted   (halted)
   );

   ////////////////////
   // clock, monitor, timeout
   ////////////////////
   initial clk = 1'b0;
   always #2 clk = ~clk;

   // writeback is stable mid-cycle
   always @(negedge clk) begin
      if (!rst && wb_valid) begin
         wb_queue.push_back({wb_reg, wb_data});
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= max_cycles) begin
         $display("timeout after %0d cycles, the processor never halted", max_cycles);
         $display("TESTS FAILED");
         $fatal(1, "simulation timed out");
      end
   end

   ////////////////////
   // helpers
   ////////////////////
   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("Error %s exp %h got %h", name, expected, actual);
         $display("TESTS FAILED");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   // next retirement against one isa step, then update the model
   task automatic expect_retire(input int idx, input logic [word_width-1:0] value);
      logic [reg_addr_width+word_width-1:0] entry;
      while (wb_queue.size() == 0) begin
         @(posedge clk);
      end
      entry = wb_queue.pop_front();
      check_value("wb_reg", idx, entry[word_width +: reg_addr_width]);
      check_value("wb_data", value, entry[word_width-1:0]);
      // r0 keeps reading zero whatever lands on it
      if (idx != 0) begin
         model_regs[idx] = value;
      end
   endtask

   // byte address, bit 0 dropped
   function automatic void store_word(input logic [word_width-1:0] addr,
                                      input logic [word_width-1:0] data);
      model_mem[addr[word_width-1:1]] = data;
   endfunction

   function automatic logic [word_width-1:0] load_word(input logic [word_width-1:0] addr);
      return model_mem[addr[word_width-1:1]];
   endfunction

   ////////////////////
   // directed tests
   ////////////////////
   task automatic test_reset();
      foreach (model_regs[i]) begin
         model_regs[i] = '0;
      end
      repeat (10) begin
         @(negedge clk);
         check_value("wb_valid", 1'b0, wb_valid);
         check_value("halted", 1'b0, halted);
      end
      rst = 1'b0;
      // pipeline still full of nops
      repeat (2) begin
         @(negedge clk);
         check_value("wb_valid", 1'b0, wb_valid);
         check_value("halted", 1'b0, halted);
      end
   endtask

   task automatic test_alu();
      expect_retire(1, model_regs[0] + 16'd12);
      expect_retire(2, model_regs[0] - 16'd7);
      // write to r0 still retires
      expect_retire(0, model_regs[0] + 16'd9);
      expect_retire(3, model_regs[1] + model_regs[2]);
      expect_retire(4, model_regs[1] - model_regs[2]);
      expect_retire(5, model_regs[1] & model_regs[2]);
      expect_retire(6, model_regs[1] | model_regs[2]);
      // r0 as a source, zero despite the write
      expect_retire(7, model_regs[0] + model_regs[1]);
      expect_retire(1, model_regs[1] - 16'd20);
   endtask

   task automatic test_dependent_chain();
      expect_retire(2, model_regs[0] + 16'd3);
      expect_retire(2, model_regs[2] + model_regs[2]);
      expect_retire(2, model_regs[2] + model_regs[2]);
      expect_retire(3, model_regs[2] - model_regs[1]);
      expect_retire(3, model_regs[3] + 16'd31);
      expect_retire(4, model_regs[3] | model_regs[2]);
      expect_retire(5, model_regs[4] & model_regs[3]);
   endtask

   task automatic test_load_store();
      expect_retire(1, model_regs[0] + 16'd16);
      expect_retire(2, model_regs[0] - 16'd11);
      // both stores retire without a writeback
      store_word(model_regs[1], model_regs[2]);
      store_word(model_regs[1] + 16'd2, model_regs[3]);
      expect_retire(4, load_word(model_regs[1]));
      expect_retire(5, load_word(model_regs[1] + 16'd2));
      // loaded value used right away
      expect_retire(6, model_regs[4] + model_regs[5]);
      // odd byte address hits the same word
      expect_retire(7, load_word(model_regs[1] + 16'd1));
   endtask

   task automatic test_branches();
      expect_retire(1, model_regs[0] + 16'd1);
      // beqz r1 falls through
      expect_retire(2, model_regs[0] + 16'd10);
      // beqz r0 skips the r3 and r4 writes
      expect_retire(6, model_regs[0] + 16'd2);
      // countdown, the back branch flushes the r5 write once
      expect_retire(6, model_regs[6] - 16'd1);
      expect_retire(6, model_regs[6] - 16'd1);
      expect_retire(5, model_regs[0] + 16'd23);
   endtask

   task automatic test_halt();
      while (!halted) begin
         @(negedge clk);
      end
      repeat (halt_watch) begin
         @(negedge clk);
         check_value("halted", 1'b1, halted);
         check_value("wb_valid", 1'b0, wb_valid);
      end
      @(posedge clk);
      check_value("wb_queue size", 0, wb_queue.size());
   endtask

   initial begin
      rst = 1'b1;
      test_reset();
      test_alu();
      test_dependent_chain();
      test_load_store();
      test_branches();
      test_halt();
      $display("TESTS PASSED");
      $finish;
   end

endmodule

/* cpu_top.f */
hdl/cpu_pkg.sv
hdl/instr_mem.sv
hdl/data_mem.sv
hdl/reg_file.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_wb_stage.sv
hdl/cpu_top.sv
testbench/tb_cpu_top.sv

/* Bender.yml */
package:
  name: cpu_top

sources:
  # rtl, package first
  - hdl/cpu_pkg.sv
  - hdl/instr_mem.sv
  - hdl/data_mem.sv
  - hdl/reg_file.sv
  - hdl/fetch_stage.sv
  - hdl/decode_stage.sv
  - hdl/execute_stage.sv
  - hdl/mem_wb_stage.sv
  - hdl/cpu_top.sv
  - target: test
    files:
      - testbench/tb_cpu_top.sv

/* prog.hex */
// program image for tb_cpu_top, one 16-bit instruction per word, from address 0
// word fields: op[15:12] rd[11:9] rs[8:6], then rt[5:3] or a signed imm[5:0]
// alu and addi: r1=12, r2=-7, r0 write, add/sub/and/or, r7=r0+r1, r1-=20
520C 5439 5009
1650 2850 3A50 4C50
1E08 526C
// dependent chain on r2, then r3, r4, r5
5403 1490 1490 2688
56DF 48D0 3B18
// r1=16, r2=-11, st to 16 and 18, ld both back, add, ld at byte 17
5210 5435 7440 7642
6840 6A42 1D28 6E41
// beqz not taken, beqz r0 over r3/r4, countdown loop on r6, r5=23
5201 8042 540A 8002
5615 5816 5C02 5DBF
8181 803D 5A17
// halt, the two addi after it never retire
9000 5E05 5E06
